// ==== all.f ====
design/tpu_pkg.sv
design/tpu_ram.sv
design/tpu_cfg.sv
design/tpu_control.sv
design/tpu_matmul.sv
design/tpu_result.sv
design/tpu_top.sv
sim/tb_tpu.sv

// ==== design/tpu_cfg.sv ====
`timescale 1ns/1ps

module tpu_cfg (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [tpu_pkg::reg_addr_w-1:0]  paddr,
  input  logic                            pwrite,
  input  logic                            psel,
  input  logic                            penable,
  input  logic [tpu_pkg::reg_data_w-1:0]  pwdata,
  output logic [tpu_pkg::reg_data_w-1:0]  prdata,
  output logic                            pready,
  output tpu_pkg::cfg_t                   cfg,
  output logic                            start,
  input  logic                            done
);
  import tpu_pkg::*;

  logic wr_en;
  logic done_status;

  // write lands in the access phase, never any wait states
  assign wr_en  = psel && penable && pwrite;
  assign pready = 1'b1;

  //////////////////////////////////////////////////////////////////////////////
  // register writes
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg   <= '0;
      start <= 1'b0;
    end else begin
      // start only lives for one cycle
      start <= 1'b0;
      if (wr_en) begin
        case (paddr)
          reg_ctrl: begin
            start           <= pwdata[0];
            cfg.enable_norm <= pwdata[1];
            cfg.enable_relu <= pwdata[2];
          end
          reg_addr_a:  cfg.addr_a <= pwdata[addr_w-1:0];
          reg_addr_b:  cfg.addr_b <= pwdata[addr_w-1:0];
          reg_addr_c:  cfg.addr_c <= pwdata[addr_w-1:0];
          reg_stride: begin
            // packed a, b, c from the low nibble up
            cfg.stride_a <= pwdata[stride_w-1:0];
            cfg.stride_b <= pwdata[2*stride_w-1:stride_w];
            cfg.stride_c <= pwdata[3*stride_w-1:2*stride_w];
          end
          reg_mean:    cfg.mean    <= pwdata[mean_w-1:0];
          reg_inv_var: cfg.inv_var <= pwdata[inv_var_w-1:0];
          default: ;
        endcase
      end
    end
  end

  // sticky done, a new start clears it
  always_ff @(posedge clk) begin
    if (reset) begin
      done_status <= 1'b0;
    end else if (start) begin
      done_status <= 1'b0;
    end else if (done) begin
      done_status <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////////////

  always_comb begin
    prdata = '0;
    case (paddr)
      // start self-clears so it reads as zero
      reg_ctrl:    prdata = reg_data_w'({cfg.enable_relu, cfg.enable_norm, 1'b0});
      reg_status:  prdata = reg_data_w'(done_status);
      reg_addr_a:  prdata = reg_data_w'(cfg.addr_a);
      reg_addr_b:  prdata = reg_data_w'(cfg.addr_b);
      reg_addr_c:  prdata = reg_data_w'(cfg.addr_c);
      reg_stride:  prdata = reg_data_w'({cfg.stride_c, cfg.stride_b, cfg.stride_a});
      // mean reads back zero-extended
      reg_mean:    prdata = reg_data_w'($unsigned(cfg.mean));
      reg_inv_var: prdata = reg_data_w'(cfg.inv_var);
      default:     prdata = '0;
    endcase
  end

endmodule

// ==== design/tpu_control.sv ====
`timescale 1ns/1ps

module tpu_control (
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  input  logic       row_written,
  output logic       row_start,
  output logic [1:0] row_index,
  output logic       busy,
  output logic       done
);
  import tpu_pkg::*;

  logic       launch;
  logic       issuing;
  // row in the upper two bits, cycle of the row in the lower two
  logic [3:0] issue_cnt;
  logic [1:0] wr_cnt;

  // start while a run is going is dropped
  assign launch    = start && !busy;
  // first row goes out in the start cycle itself
  assign row_start = launch || (issuing && (issue_cnt[1:0] == 2'd0));
  assign row_index = issue_cnt[3:2];

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      issuing   <= 1'b0;
      issue_cnt <= '0;
      wr_cnt    <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      if (launch) begin
        busy      <= 1'b1;
        issuing   <= 1'b1;
        issue_cnt <= 4'd1;
      end else if (issuing) begin
        // wraps back to zero once all four rows have had their slot
        issue_cnt <= issue_cnt + 4'd1;
        if (issue_cnt == 4'(mat_size * mat_size - 1)) begin
          issuing <= 1'b0;
        end
      end
      // last write back closes the run
      if (row_written) begin
        wr_cnt <= wr_cnt + 2'd1;
        if (wr_cnt == 2'(mat_size - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== design/tpu_matmul.sv ====
`timescale 1ns/1ps

module tpu_matmul (
  input  logic                        clk,
  input  logic                        reset,
  input  tpu_pkg::cfg_t               cfg,
  input  logic                        row_start,
  input  logic [1:0]                  row_index,
  input  logic                        busy,
  input  logic [tpu_pkg::row_w-1:0]   a_rdata,
  input  logic [tpu_pkg::row_w-1:0]   b_rdata,
  output logic [tpu_pkg::addr_w-1:0]  a_raddr,
  output logic [tpu_pkg::addr_w-1:0]  b_addr,
  output tpu_pkg::acc_row_t           acc_row
);
  import tpu_pkg::*;

  logic [1:0]                 k_cnt;
  logic                       issue;
  logic                       rd_live;
  logic                       rd_first;
  logic [1:0]                 rd_k;
  logic [row_w-1:0]           a_hold;
  logic [row_w-1:0]           a_cur;
  logic signed [data_w-1:0]   a_elem;
  logic signed [2*data_w-1:0] prod     [mat_size];
  logic signed [acc_w-1:0]    acc_q    [mat_size];
  logic signed [acc_w-1:0]    acc_next [mat_size];
  logic                       valid_q;

  //////////////////////////////////////////////////////////////////////////////
  // read issue
  //////////////////////////////////////////////////////////////////////////////

  // k runs 0..3 from row_start, b row k read in cycle k
  assign issue   = row_start || (k_cnt != 2'd0);
  // a row address only matters in cycle 0
  assign a_raddr = cfg.addr_a + addr_w'(row_index) * addr_w'(cfg.stride_a);
  assign b_addr  = cfg.addr_b + addr_w'(k_cnt) * addr_w'(cfg.stride_b);

  always_ff @(posedge clk) begin
    if (reset) begin
      k_cnt <= '0;
    end else if (!busy && !row_start) begin
      // idle engine keeps the step count parked
      k_cnt <= '0;
    end else if (issue) begin
      k_cnt <= k_cnt + 2'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // multiply-accumulate, one cycle behind the reads
  //////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_live  <= 1'b0;
      rd_first <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      rd_live  <= issue;
      rd_first <= row_start;
      // fourth product goes in this edge
      valid_q  <= rd_live && (rd_k == 2'd3);
    end
  end

  // a row arrives only once, alongside b row 0
  assign a_cur  = rd_first ? a_rdata : a_hold;
  assign a_elem = $signed(a_cur[rd_k*data_w +: data_w]);

  always_comb begin
    for (int j = 0; j < mat_size; j++) begin
      prod[j] = a_elem * $signed(b_rdata[j*data_w +: data_w]);
      // k = 0 starts a fresh sum
      acc_next[j] = (rd_k == 2'd0) ? acc_w'(prod[j]) : acc_q[j] + prod[j];
    end
  end

  always_ff @(posedge clk) begin
    rd_k <= k_cnt;
    if (rd_first) begin
      a_hold <= a_rdata;
    end
    if (rd_live) begin
      acc_q <= acc_next;
    end
  end

  // sums hold through the valid cycle, the next row clears them a cycle later
  always_comb begin
    acc_row.valid = valid_q;
    for (int j = 0; j < mat_size; j++) begin
      acc_row.lane[j] = acc_q[j];
    end
  end

endmodule

// ==== design/tpu_pkg.sv ====
package tpu_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////////////

  // rows and lanes per matrix
  localparam int mat_size   = 4;
  localparam int data_w     = 8;
  // one memory word carries one matrix row, lane 0 in the low byte
  localparam int row_w      = mat_size * data_w;
  localparam int acc_w      = 20;
  localparam int addr_w     = 6;
  localparam int ram_depth  = 1 << addr_w;
  localparam int stride_w   = 4;
  localparam int reg_addr_w = 8;
  localparam int reg_data_w = 32;

  // normalization operands
  localparam int mean_w     = 16;
  localparam int inv_var_w  = 8;
  localparam int norm_shift = 4;

  // signed 8-bit output range
  localparam int sat_max    = 127;
  localparam int sat_min    = -128;

  //////////////////////////////////////////////////////////////////////////////
  // register offsets
  //////////////////////////////////////////////////////////////////////////////

  localparam logic [reg_addr_w-1:0] reg_ctrl    = 8'h00;
  localparam logic [reg_addr_w-1:0] reg_status  = 8'h04;
  localparam logic [reg_addr_w-1:0] reg_addr_a  = 8'h08;
  localparam logic [reg_addr_w-1:0] reg_addr_b  = 8'h0C;
  localparam logic [reg_addr_w-1:0] reg_addr_c  = 8'h10;
  localparam logic [reg_addr_w-1:0] reg_stride  = 8'h14;
  localparam logic [reg_addr_w-1:0] reg_mean    = 8'h18;
  localparam logic [reg_addr_w-1:0] reg_inv_var = 8'h1C;

  // engine configuration as held by the register block
  typedef struct packed {
    logic [addr_w-1:0]          addr_a;
    logic [addr_w-1:0]          addr_b;
    logic [addr_w-1:0]          addr_c;
    logic [stride_w-1:0]        stride_a;
    logic [stride_w-1:0]        stride_b;
    logic [stride_w-1:0]        stride_c;
    logic signed [mean_w-1:0]   mean;
    logic [inv_var_w-1:0]       inv_var;
    logic                       enable_norm;
    logic                       enable_relu;
  } cfg_t;

  // one finished row of accumulators, valid for a single cycle
  typedef struct packed {
    logic                             valid;
    logic [mat_size-1:0][acc_w-1:0]   lane;
  } acc_row_t;

endpackage

// ==== design/tpu_ram.sv ====
`timescale 1ns/1ps

module tpu_ram (
  input  logic                          clk,
  input  logic [tpu_pkg::addr_w-1:0]    addr0,
  input  logic [tpu_pkg::row_w-1:0]     d0,
  input  logic [tpu_pkg::mat_size-1:0]  we0,
  output logic [tpu_pkg::row_w-1:0]     q0,
  input  logic [tpu_pkg::addr_w-1:0]    addr1,
  input  logic [tpu_pkg::row_w-1:0]     d1,
  input  logic [tpu_pkg::mat_size-1:0]  we1,
  output logic [tpu_pkg::row_w-1:0]     q1
);
  import tpu_pkg::*;

  logic [row_w-1:0] mem [ram_depth];

  // both ports in one process, reads see the word before this edge's write
  always_ff @(posedge clk) begin
    q0 <= mem[addr0];
    q1 <= mem[addr1];
    for (int b = 0; b < mat_size; b++) begin
      // byte lane b of each port
      if (we0[b]) begin
        mem[addr0][b*data_w +: data_w] <= d0[b*data_w +: data_w];
      end
      // port 1 lands last on a same-address collision
      if (we1[b]) begin
        mem[addr1][b*data_w +: data_w] <= d1[b*data_w +: data_w];
      end
    end
  end

endmodule

// ==== design/tpu_result.sv ====
`timescale 1ns/1ps

module tpu_result (
  input  logic                          clk,
  input  logic                          reset,
  input  tpu_pkg::cfg_t                 cfg,
  input  tpu_pkg::acc_row_t             acc_row,
  input  logic [tpu_pkg::addr_w-1:0]    a_raddr,
  output logic [tpu_pkg::addr_w-1:0]    a_addr,
  output logic [tpu_pkg::row_w-1:0]     a_wdata,
  output logic [tpu_pkg::mat_size-1:0]  a_we,
  output logic                          row_written
);
  import tpu_pkg::*;

  logic [1:0]        wr_row;
  logic              wr_valid;
  logic [addr_w-1:0] wr_addr;
  logic [row_w-1:0]  wr_data;
  logic [row_w-1:0]  row_out;

  // norm, then saturate to 8 bits, then relu
  function automatic logic [data_w-1:0] shape_lane(input logic signed [acc_w-1:0] acc,
                                                   input cfg_t c);
    logic signed [acc_w:0]          diff;
    logic signed [acc_w+data_w+1:0] val;
    logic [data_w-1:0]              sat;
    diff = acc - c.mean;
    if (c.enable_norm) begin
      // inv_var is unsigned, widened with a zero sign bit
      val = (diff * $signed({1'b0, c.inv_var})) >>> norm_shift;
    end else begin
      val = acc;
    end
    if (val > sat_max) begin
      sat = data_w'(sat_max);
    end else if (val < sat_min) begin
      sat = data_w'(sat_min);
    end else begin
      sat = val[data_w-1:0];
    end
    if (c.enable_relu && sat[data_w-1]) begin
      sat = '0;
    end
    return sat;
  endfunction

  always_comb begin
    for (int j = 0; j < mat_size; j++) begin
      row_out[j*data_w +: data_w] = shape_lane(acc_row.lane[j], cfg);
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // write-back register
  //////////////////////////////////////////////////////////////////////////////

  // row count wraps after four rows, so every run restarts at addr_c
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_valid <= 1'b0;
      wr_row   <= '0;
    end else begin
      wr_valid <= acc_row.valid;
      if (acc_row.valid) begin
        wr_row <= wr_row + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_row.valid) begin
      wr_data <= row_out;
      wr_addr <= cfg.addr_c + addr_w'(wr_row) * addr_w'(cfg.stride_c);
    end
  end

  // write falls in cycle 2 of the next row, clear of its a read
  assign a_addr      = wr_valid ? wr_addr : a_raddr;
  assign a_wdata     = wr_data;
  assign a_we        = {mat_size{wr_valid}};
  assign row_written = wr_valid;

endmodule

// ==== design/tpu_top.sv ====
`timescale 1ns/1ps

module tpu_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [tpu_pkg::reg_addr_w-1:0]  paddr,
  input  logic                            pwrite,
  input  logic                            psel,
  input  logic                            penable,
  input  logic [tpu_pkg::reg_data_w-1:0]  pwdata,
  output logic [tpu_pkg::reg_data_w-1:0]  prdata,
  output logic                            pready,
  input  logic [tpu_pkg::addr_w-1:0]      bram_addr_a_ext,
  input  logic [tpu_pkg::row_w-1:0]       bram_wdata_a_ext,
  input  logic [tpu_pkg::mat_size-1:0]    bram_we_a_ext,
  output logic [tpu_pkg::row_w-1:0]       bram_rdata_a_ext,
  input  logic [tpu_pkg::addr_w-1:0]      bram_addr_b_ext,
  input  logic [tpu_pkg::row_w-1:0]       bram_wdata_b_ext,
  input  logic [tpu_pkg::mat_size-1:0]    bram_we_b_ext,
  output logic [tpu_pkg::row_w-1:0]       bram_rdata_b_ext
);
  import tpu_pkg::*;

  cfg_t                cfg;
  acc_row_t            acc_row;
  logic                start;
  logic                done;
  logic                row_start;
  logic [1:0]          row_index;
  logic                busy;
  logic                row_written;
  logic [addr_w-1:0]   a_raddr;
  logic [addr_w-1:0]   a_addr;
  logic [row_w-1:0]    a_wdata;
  logic [mat_size-1:0] a_we;
  logic [row_w-1:0]    a_rdata;
  logic [addr_w-1:0]   b_addr;
  logic [row_w-1:0]    b_rdata;

  //////////////////////////////////////////////////////////////////////////////
  // memories, port 1 faces the outside
  //////////////////////////////////////////////////////////////////////////////

  // a holds inputs and receives the results
  tpu_ram u_ram_a (
    .clk   (clk),
    .addr0 (a_addr),
    .d0    (a_wdata),
    .we0   (a_we),
    .q0    (a_rdata),
    .addr1 (bram_addr_a_ext),
    .d1    (bram_wdata_a_ext),
    .we1   (bram_we_a_ext),
    .q1    (bram_rdata_a_ext)
  );

  // engine only reads b
  tpu_ram u_ram_b (
    .clk   (clk),
    .addr0 (b_addr),
    .d0    ('0),
    .we0   ('0),
    .q0    (b_rdata),
    .addr1 (bram_addr_b_ext),
    .d1    (bram_wdata_b_ext),
    .we1   (bram_we_b_ext),
    .q1    (bram_rdata_b_ext)
  );

  tpu_cfg u_cfg (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .pwrite  (pwrite),
    .psel    (psel),
    .penable (penable),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .cfg     (cfg),
    .start   (start),
    .done    (done)
  );

  tpu_control u_control (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .row_written (row_written),
    .row_start   (row_start),
    .row_index   (row_index),
    .busy        (busy),
    .done        (done)
  );

  tpu_matmul u_matmul (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .row_start (row_start),
    .row_index (row_index),
    .busy      (busy),
    .a_rdata   (a_rdata),
    .b_rdata   (b_rdata),
    .a_raddr   (a_raddr),
    .b_addr    (b_addr),
    .acc_row   (acc_row)
  );

  tpu_result u_result (
    .clk         (clk),
    .reset       (reset),
    .cfg         (cfg),
    .acc_row     (acc_row),
    .a_raddr     (a_raddr),
    .a_addr      (a_addr),
    .a_wdata     (a_wdata),
    .a_we        (a_we),
    .row_written (row_written)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_tpu -f all.f -o tb_tpu_sim
./obj_dir/tb_tpu_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi

// ==== sim/tb_tpu.sv ====
`timescale 1ns/1ps

module tb_tpu;
  import tpu_pkg::*;

  // read/write registers and the field bits each one keeps
  localparam logic [reg_addr_w-1:0] rw_offs [7] = '{reg_ctrl, reg_addr_a, reg_addr_b,
                                                     reg_addr_c, reg_stride, reg_mean,
                                                     reg_inv_var};
  localparam logic [reg_data_w-1:0] rw_mask [7] = '{32'h6, 32'h3f, 32'h3f, 32'h3f,
                                                     32'hfff, 32'hffff, 32'hff};

  logic                     clk;
  logic                     reset;
  logic [reg_addr_w-1:0]    paddr;
  logic                     pwrite;
  logic                     psel;
  logic                     penable;
  logic [reg_data_w-1:0]    pwdata;
  logic [reg_data_w-1:0]    prdata;
  logic                     pready;
  logic [addr_w-1:0]        bram_addr_a_ext;
  logic [row_w-1:0]         bram_wdata_a_ext;
  logic [mat_size-1:0]      bram_we_a_ext;
  logic [row_w-1:0]         bram_rdata_a_ext;
  logic [addr_w-1:0]        bram_addr_b_ext;
  logic [row_w-1:0]         bram_wdata_b_ext;
  logic [mat_size-1:0]      bram_we_b_ext;
  logic [row_w-1:0]         bram_rdata_b_ext;

  // operands of the current run and the expected image of memory a
  logic signed [data_w-1:0] mat_a [mat_size][mat_size];
  logic signed [data_w-1:0] mat_b [mat_size][mat_size];
  logic [row_w-1:0]         shadow_a [ram_depth];
  int                       errors;
  int                       tests_failed;
  int                       test_mark;

  tpu_top i_dut (
    .clk              (clk),
    .reset            (reset),
    .paddr            (paddr),
    .pwrite           (pwrite),
    .psel             (psel),
    .penable          (penable),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .bram_addr_a_ext  (bram_addr_a_ext),
    .bram_wdata_a_ext (bram_wdata_a_ext),
    .bram_we_a_ext    (bram_we_a_ext),
    .bram_rdata_a_ext (bram_rdata_a_ext),
    .bram_addr_b_ext  (bram_addr_b_ext),
    .bram_wdata_b_ext (bram_wdata_b_ext),
    .bram_we_b_ext    (bram_we_b_ext),
    .bram_rdata_b_ext (bram_rdata_b_ext)
  );

  // 20 ns period
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // one output lane: optional norm, saturate to 8 bits, optional relu
  function automatic logic [data_w-1:0] expected_lane(input longint acc, input bit norm,
                                                     input bit relu, input longint mean,
                                                     input longint inv_var);
    longint v;
    v = acc;
    if (norm) begin
      v = ((acc - mean) * inv_var) >>> norm_shift;
    end
    if (v > 127) begin
      v = 127;
    end else if (v < -128) begin
      v = -128;
    end
    if (relu && v < 0) begin
      v = 0;
    end
    return data_w'(v);
  endfunction

  // background word, every address bit shows up in it
  function automatic logic [row_w-1:0] fill_word(input logic [addr_w-1:0] addr);
    return {2'b10, addr, 2'b01, ~addr, 2'b11, addr, 2'b00, ~addr};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks, all inputs change on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic reg_write(input logic [reg_addr_w-1:0] addr,
                           input logic [reg_data_w-1:0] data);
    int waits;
    waits = 0;
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    // access phase holds until pready
    while (!pready && waits < 16) begin
      @(negedge clk);
      waits++;
    end
    if (!pready) begin
      $display("pready never rose on write to 0x%02h", addr);
      errors++;
    end
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_read(input logic [reg_addr_w-1:0] addr,
                          output logic [reg_data_w-1:0] data);
    int waits;
    waits = 0;
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    while (!pready && waits < 16) begin
      @(negedge clk);
      waits++;
    end
    if (!pready) begin
      $display("pready never rose on read of 0x%02h", addr);
      errors++;
    end
    // prdata is settled half a cycle after the edge
    data    = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic mem_load_a(input logic [addr_w-1:0] addr, input logic [row_w-1:0] data);
    @(negedge clk);
    bram_addr_a_ext  = addr;
    bram_wdata_a_ext = data;
    bram_we_a_ext    = '1;
    @(negedge clk);
    bram_we_a_ext    = '0;
    shadow_a[addr]   = data;
  endtask

  task automatic mem_load_b(input logic [addr_w-1:0] addr, input logic [row_w-1:0] data);
    @(negedge clk);
    bram_addr_b_ext  = addr;
    bram_wdata_b_ext = data;
    bram_we_b_ext    = '1;
    @(negedge clk);
    bram_we_b_ext    = '0;
  endtask

  // one-cycle read latency, sampled on the following falling edge
  task automatic mem_read_a(input logic [addr_w-1:0] addr, output logic [row_w-1:0] data);
    @(negedge clk);
    bram_addr_a_ext = addr;
    bram_we_a_ext   = '0;
    @(negedge clk);
    data = bram_rdata_a_ext;
  endtask

  // same timing on memory b
  task automatic mem_read_b(input logic [addr_w-1:0] addr, output logic [row_w-1:0] data);
    @(negedge clk);
    bram_addr_b_ext = addr;
    bram_we_b_ext   = '0;
    @(negedge clk);
    data = bram_rdata_b_ext;
  endtask

  // poll the sticky done bit
  task automatic wait_done();
    logic [reg_data_w-1:0] rd;
    int                    cycles;
    rd     = '0;
    cycles = 0;
    while (!rd[0] && cycles < 100) begin
      reg_read(reg_status, rd);
      cycles += 3;
    end
    if (!rd[0]) begin
      $display("timeout: done bit not set within 100 cycles at %0t", $time);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one complete run: load, program, start, wait, compare all of memory a
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_matmul(input bit norm, input bit relu, input bit narrow,
                            input bit busy_start,
                            input logic [addr_w-1:0] aa, input logic [addr_w-1:0] ab,
                            input logic [addr_w-1:0] ac, input logic [stride_w-1:0] sa,
                            input logic [stride_w-1:0] sb, input logic [stride_w-1:0] sc,
                            input logic [15:0] mean, input logic [7:0] inv_var);
    logic [row_w-1:0]      word;
    logic [row_w-1:0]      exp_word;
    logic [addr_w-1:0]     addr;
    logic [reg_data_w-1:0] rd;
    logic [reg_data_w-1:0] ctrl;
    longint                acc;
    for (int i = 0; i < mat_size; i++) begin
      for (int k = 0; k < mat_size; k++) begin
        // narrow a keeps the normalized values out of saturation now and then
        mat_a[i][k] = narrow ? data_w'(int'($urandom_range(0, 7)) - 4) : data_w'($urandom);
        mat_b[i][k] = data_w'($urandom);
      end
    end
    // lane j in byte j
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        word[j*data_w +: data_w] = mat_a[i][j];
      end
      mem_load_a(aa + addr_w'(i * sa), word);
      for (int j = 0; j < mat_size; j++) begin
        word[j*data_w +: data_w] = mat_b[i][j];
      end
      mem_load_b(ab + addr_w'(i * sb), word);
    end
    reg_write(reg_addr_a, reg_data_w'(aa));
    reg_write(reg_addr_b, reg_data_w'(ab));
    reg_write(reg_addr_c, reg_data_w'(ac));
    reg_write(reg_stride, reg_data_w'({sc, sb, sa}));
    reg_write(reg_mean, reg_data_w'(mean));
    reg_write(reg_inv_var, reg_data_w'(inv_var));
    ctrl = reg_data_w'({relu, norm, 1'b1});
    reg_write(reg_ctrl, ctrl);
    // start clears the sticky done bit
    reg_read(reg_status, rd);
    if (rd[0] !== 1'b0) begin
      $display("FAIL t=%0t prdata[status].done got %b expected 0", $time, rd[0]);
      errors++;
    end
    // second start lands while rows are still in flight
    if (busy_start) begin
      reg_write(reg_ctrl, ctrl);
    end
    wait_done();
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        acc = 0;
        for (int k = 0; k < mat_size; k++) begin
          acc += longint'(mat_a[i][k]) * longint'(mat_b[k][j]);
        end
        word[j*data_w +: data_w] = expected_lane(acc, norm, relu,
                                                 longint'($signed(mean)),
                                                 longint'(inv_var));
      end
      shadow_a[ac + addr_w'(i * sc)] = word;
    end
    // every word of a, so untouched words are checked too
    for (int n = 0; n < ram_depth; n++) begin
      addr = addr_w'(n);
      mem_read_a(addr, word);
      if (word !== shadow_a[addr]) begin
        $display("FAIL t=%0t bram_rdata_a_ext[%0d] got 0x%08h expected 0x%08h",
                 $time, addr, word, shadow_a[addr]);
        errors++;
      end
    end
    // b rows come back unchanged through port 1
    for (int i = 0; i < mat_size; i++) begin
      for (int j = 0; j < mat_size; j++) begin
        exp_word[j*data_w +: data_w] = mat_b[i][j];
      end
      addr = ab + addr_w'(i * sb);
      mem_read_b(addr, word);
      if (word !== exp_word) begin
        $display("FAIL t=%0t bram_rdata_b_ext[%0d] got 0x%08h expected 0x%08h",
                 $time, addr, word, exp_word);
        errors++;
      end
    end
  endtask

  task automatic finish_test(input int num, input string name);
    if (errors == test_mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - test_mark);
      tests_failed++;
    end
    test_mark = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic [reg_data_w-1:0] rd;
    logic [reg_data_w-1:0] wr [7];
    clk              = 1'b0;
    reset            = 1'b1;
    paddr            = '0;
    pwrite           = 1'b0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwdata           = '0;
    bram_addr_a_ext  = '0;
    bram_wdata_a_ext = '0;
    bram_we_a_ext    = '0;
    bram_addr_b_ext  = '0;
    bram_wdata_b_ext = '0;
    bram_we_b_ext    = '0;
    errors           = 0;
    tests_failed     = 0;
    test_mark        = 0;
    void'($urandom(32'hab223036));
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // reset values, 0x20 is unmapped
    for (int r = 0; r < 9; r++) begin
      reg_read(reg_addr_w'(r * 4), rd);
      if (rd !== '0) begin
        $display("FAIL t=%0t prdata[0x%02h] got 0x%08h expected 0x00000000",
                 $time, r * 4, rd);
        errors++;
      end
    end
    // start bit kept clear so nothing runs
    for (int r = 0; r < 7; r++) begin
      wr[r] = $urandom;
      if (r == 0) begin
        wr[r][0] = 1'b0;
      end
      reg_write(rw_offs[r], wr[r]);
    end
    for (int r = 0; r < 7; r++) begin
      reg_read(rw_offs[r], rd);
      if (rd !== (wr[r] & rw_mask[r])) begin
        $display("FAIL t=%0t prdata[0x%02h] got 0x%08h expected 0x%08h",
                 $time, rw_offs[r], rd, wr[r] & rw_mask[r]);
        errors++;
      end
    end
    reg_read(reg_status, rd);
    if (rd !== '0) begin
      $display("FAIL t=%0t prdata[status] got 0x%08h expected 0x00000000", $time, rd);
      errors++;
    end
    finish_test(1, "register reset and readback");

    // known background in all of a
    for (int n = 0; n < ram_depth; n++) begin
      mem_load_a(addr_w'(n), fill_word(addr_w'(n)));
    end
    run_matmul(1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 6'd0, 6'd8, 4'd1, 4'd1, 4'd1, 16'd0, 8'd0);
    finish_test(2, "plain multiply");

    run_matmul(1'b1, 1'b0, 1'b1, 1'b0, 6'd16, 6'd4, 6'd24, 4'd1, 4'd1, 4'd1,
               16'(int'($urandom_range(0, 2047)) - 1024), 8'($urandom_range(1, 32)));
    finish_test(3, "normalization");

    // a kept below 16, c in 32..47
    run_matmul(1'b1, 1'b1, 1'b1, 1'b0,
               6'($urandom_range(0, 3)), 6'($urandom_range(0, 40)),
               6'(32 + $urandom_range(0, 3)), 4'($urandom_range(2, 4)),
               4'($urandom_range(2, 7)), 4'($urandom_range(2, 4)),
               16'(int'($urandom_range(0, 2047)) - 1024), 8'($urandom_range(1, 32)));
    finish_test(4, "norm, relu and strides");

    // two runs in a row, the second with a start during busy
    run_matmul(1'b0, 1'b1, 1'b0, 1'b0, 6'd48, 6'd20, 6'd16, 4'd3, 4'd2, 4'd2, 16'd0, 8'd0);
    run_matmul(1'b0, 1'b1, 1'b0, 1'b1, 6'd48, 6'd20, 6'd16, 4'd3, 4'd2, 4'd2, 16'd0, 8'd0);
    finish_test(5, "back-to-back runs");

    $display("tests run 5, tests failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
